/* design/node_pkg.sv */
`default_nettype none

package node_pkg;

	localparam int N_INPUTS = 15;
	localparam int LANE_ITEMS = (N_INPUTS + 1) / 2;

	localparam int FP_BIAS = 127;
	localparam logic [7:0] FP_EXP_MAX = 8'd254;

	// APB byte addresses of the register map.
	localparam logic [11:0] ADDR_ACT_BASE = 12'h000;
	localparam logic [11:0] ADDR_WGT_BASE = 12'h040;
	localparam logic [11:0] ADDR_CTRL = 12'h080;
	localparam logic [11:0] ADDR_STATUS = 12'h084;
	localparam logic [11:0] ADDR_RESULT = 12'h088;

	typedef struct packed {
		logic sign;
		logic [7:0] exponent;
		logic [22:0] mantissa;
	} float_fields_t;

	// Single-precision word, seen as raw bits or as its fields.
	typedef union packed {
		logic [31:0] raw;
		float_fields_t f;
	} float_word_t;

	typedef struct packed {
		float_word_t act;
		float_word_t wgt;
	} mac_operands_t;

endpackage

`default_nettype wire

/* design/float_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module float_mult import node_pkg::*; (
	input float_word_t a,
	input float_word_t b,
	output float_word_t p
);

	logic [23:0] sig_a;
	logic [23:0] sig_b;
	logic [47:0] prod;
	logic signed [9:0] exp_sum;
	logic signed [9:0] exp_norm;
	logic [22:0] mant;

	assign sig_a = {1'b1, a.f.mantissa};
	assign sig_b = {1'b1, b.f.mantissa};
	assign prod = sig_a * sig_b;
	assign exp_sum = 10'(a.f.exponent) + 10'(b.f.exponent) - 10'(FP_BIAS);

	always_comb
	begin
		// The significand product lies in [1, 4), so one shift is enough.
		if (prod[47])
		begin
			exp_norm = exp_sum + 10'sd1;
			mant = prod[46:24];
		end
		else
		begin
			exp_norm = exp_sum;
			mant = prod[45:23];
		end

		p = '0;
		if (a.f.exponent == '0 || b.f.exponent == '0 || exp_norm <= 0)
			p = '0;
		else if (exp_norm > $signed({2'b00, FP_EXP_MAX}))
		begin
			p.f.sign = a.f.sign ^ b.f.sign;
			p.f.exponent = FP_EXP_MAX;
			p.f.mantissa = '1;
		end
		else
		begin
			p.f.sign = a.f.sign ^ b.f.sign;
			p.f.exponent = exp_norm[7:0];
			p.f.mantissa = mant;
		end
	end

endmodule

`default_nettype wire

/* design/float_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module float_adder import node_pkg::*; (
	input float_word_t a,
	input float_word_t b,
	output float_word_t s
);

	float_word_t op_big;
	float_word_t op_small;
	logic [23:0] sig_big;
	logic [23:0] sig_small;
	logic [23:0] aligned;
	logic [7:0] exp_diff;
	logic sub;
	logic [24:0] sum;
	logic [4:0] lz;
	logic [23:0] norm;

	// Order by magnitude so the result takes the sign of the larger operand.
	always_comb
	begin
		if (a.raw[30:0] >= b.raw[30:0])
		begin
			op_big = a;
			op_small = b;
		end
		else
		begin
			op_big = b;
			op_small = a;
		end
	end

	// Subnormals are flushed, so a zero exponent means a zero significand.
	assign sig_big = (op_big.f.exponent != '0) ? {1'b1, op_big.f.mantissa} : '0;
	assign sig_small = (op_small.f.exponent != '0) ? {1'b1, op_small.f.mantissa} : '0;
	assign exp_diff = op_big.f.exponent - op_small.f.exponent;
	assign aligned = (exp_diff > 8'd23) ? '0 : (sig_small >> exp_diff);
	assign sub = op_big.f.sign ^ op_small.f.sign;
	assign sum = sub ? ({1'b0, sig_big} - {1'b0, aligned})
		: ({1'b0, sig_big} + {1'b0, aligned});

	always_comb
	begin
		lz = 5'd24;
		for (int i = 0; i < 24; i++)
		begin
			if (sum[i])
				lz = 5'(23 - i);
		end
	end

	assign norm = sum[23:0] << lz;

	always_comb
	begin
		s = '0;
		if (sum == '0)
			s = '0;
		else if (sum[24])
		begin
			s.f.sign = op_big.f.sign;
			if (op_big.f.exponent >= FP_EXP_MAX)
			begin
				s.f.exponent = FP_EXP_MAX;
				s.f.mantissa = '1;
			end
			else
			begin
				s.f.exponent = op_big.f.exponent + 8'd1;
				s.f.mantissa = sum[23:1];
			end
		end
		else if (op_big.f.exponent <= 8'(lz))
			s = '0;
		else
		begin
			s.f.sign = op_big.f.sign;
			s.f.exponent = op_big.f.exponent - 8'(lz);
			s.f.mantissa = norm[22:0];
		end
	end

endmodule

`default_nettype wire

/* design/node_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module node_lane import node_pkg::*; #(
	parameter int LANE = 0
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input mac_operands_t operands,
	output logic [3:0] lane_idx,
	output float_word_t partial,
	output logic last
);

	float_word_t mult_out;
	float_word_t product;
	float_word_t acc_in;
	float_word_t acc_sum;
	logic [3:0] cnt;
	logic active;
	logic [4:0] gidx;

	// Item 0 is fetched in the start cycle itself.
	assign lane_idx = start ? '0 : cnt;
	assign gidx = 5'(2 * lane_idx + LANE);

	float_mult mult_i (
		.a(operands.act),
		.b(operands.wgt),
		.p(mult_out)
	);

	// Past the end of the register file the product counts as zero.
	assign product = (gidx < 5'(N_INPUTS)) ? mult_out : '0;
	assign acc_in = start ? '0 : partial;

	float_adder add_i (
		.a(acc_in),
		.b(product),
		.s(acc_sum)
	);

	always_ff @(posedge clk)
	begin
		if (start || active)
			partial <= acc_sum;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt <= '0;
			active <= 1'b0;
			last <= 1'b0;
		end
		else if (start)
		begin
			cnt <= 4'd1;
			active <= 1'b1;
			last <= 1'b0;
		end
		else if (active)
		begin
			cnt <= cnt + 4'd1;
			if (cnt == 4'(LANE_ITEMS - 1))
			begin
				active <= 1'b0;
				last <= 1'b1;
			end
		end
		else
			last <= 1'b0;
	end

endmodule

`default_nettype wire

/* design/node_combine.sv */
`timescale 1ns/1ps
`default_nettype none

module node_combine import node_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic sample,
	input float_word_t partial_even,
	input float_word_t partial_odd,
	output float_word_t result,
	output logic result_valid
);

	float_word_t total;

	float_adder add_i (
		.a(partial_even),
		.b(partial_odd),
		.s(total)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			result <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= sample;
			// The ReLU clamps a negative sum to zero.
			if (sample)
				result <= total.f.sign ? '0 : total;
		end
	end

endmodule

`default_nettype wire

/* design/node_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module node_apb_regs import node_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [11:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic start,
	input logic [3:0] lane_idx_even,
	input logic [3:0] lane_idx_odd,
	output mac_operands_t operands_even,
	output mac_operands_t operands_odd,
	input float_word_t result,
	input logic result_valid
);

	float_word_t act_mem [N_INPUTS];
	float_word_t wgt_mem [N_INPUTS];
	float_word_t result_q;
	logic busy;
	logic done;
	logic access;
	logic [3:0] reg_idx;
	logic act_hit;
	logic wgt_hit;
	logic ctrl_hit;
	logic status_hit;
	logic result_hit;
	logic mapped;
	logic wr_ok;
	logic start_req;

	function automatic mac_operands_t fetch(input logic [4:0] gidx);
		mac_operands_t ops;
		ops = '0;
		if (gidx < 5'(N_INPUTS))
		begin
			ops.act = act_mem[gidx[3:0]];
			ops.wgt = wgt_mem[gidx[3:0]];
		end
		return ops;
	endfunction

	assign pready = 1'b1;
	assign access = psel && penable;
	assign reg_idx = paddr[5:2];

	assign act_hit = (paddr[11:6] == ADDR_ACT_BASE[11:6]) && (paddr[1:0] == 2'b00)
		&& (reg_idx < 4'(N_INPUTS));
	assign wgt_hit = (paddr[11:6] == ADDR_WGT_BASE[11:6]) && (paddr[1:0] == 2'b00)
		&& (reg_idx < 4'(N_INPUTS));
	assign ctrl_hit = (paddr == ADDR_CTRL);
	assign status_hit = (paddr == ADDR_STATUS);
	assign result_hit = (paddr == ADDR_RESULT);
	assign mapped = act_hit || wgt_hit || ctrl_hit || status_hit || result_hit;

	// Writes to the operand registers or CTRL are refused while a computation runs.
	assign pslverr = access && (!mapped || (pwrite && (status_hit || result_hit))
		|| (pwrite && busy && (act_hit || wgt_hit || ctrl_hit)));

	assign wr_ok = access && pwrite && !busy;
	assign start_req = wr_ok && ctrl_hit && pwdata[0];

	always_comb
	begin
		operands_even = fetch({lane_idx_even, 1'b0});
		operands_odd = fetch({lane_idx_odd, 1'b1});
	end

	always_comb
	begin
		prdata = '0;
		if (psel && !pwrite)
		begin
			if (act_hit)
				prdata = act_mem[reg_idx].raw;
			else if (wgt_hit)
				prdata = wgt_mem[reg_idx].raw;
			else if (status_hit)
				prdata = {30'b0, done, busy};
			else if (result_hit)
				prdata = result_q.raw;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < N_INPUTS; i++)
			begin
				act_mem[i] <= '0;
				wgt_mem[i] <= '0;
			end
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			result_q <= '0;
		end
		else
		begin
			start <= start_req;
			if (wr_ok && act_hit)
				act_mem[reg_idx].raw <= pwdata;
			if (wr_ok && wgt_hit)
				wgt_mem[reg_idx].raw <= pwdata;

			if (start_req)
			begin
				busy <= 1'b1;
				done <= 1'b0;
			end
			else if (result_valid)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end

			if (result_valid)
				result_q <= result;
		end
	end

endmodule

`default_nettype wire

/* design/node_top.sv */
`timescale 1ns/1ps
`default_nettype none

module node_top import node_pkg::*; (
	input logic pclk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [11:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic start;
	logic [3:0] lane_idx_even;
	logic [3:0] lane_idx_odd;
	mac_operands_t operands_even;
	mac_operands_t operands_odd;
	float_word_t partial_even;
	float_word_t partial_odd;
	logic last_even;
	float_word_t result;
	logic result_valid;

	node_apb_regs regs_i (
		.clk(pclk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.start(start),
		.lane_idx_even(lane_idx_even),
		.lane_idx_odd(lane_idx_odd),
		.operands_even(operands_even),
		.operands_odd(operands_odd),
		.result(result),
		.result_valid(result_valid)
	);

	node_lane #(.LANE(0)) lane_even_i (
		.clk(pclk),
		.rst_n(rst_n),
		.start(start),
		.operands(operands_even),
		.lane_idx(lane_idx_even),
		.partial(partial_even),
		.last(last_even)
	);

	// Both lanes run in lockstep, so only the even lane's last pulse is used.
	node_lane #(.LANE(1)) lane_odd_i (
		.clk(pclk),
		.rst_n(rst_n),
		.start(start),
		.operands(operands_odd),
		.lane_idx(lane_idx_odd),
		.partial(partial_odd),
		.last()
	);

	node_combine combine_i (
		.clk(pclk),
		.rst_n(rst_n),
		.sample(last_even),
		.partial_even(partial_even),
		.partial_odd(partial_odd),
		.result(result),
		.result_valid(result_valid)
	);

endmodule

`default_nettype wire

/* testbench/node_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module node_checker import node_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pslverr,
	input logic busy,
	input logic done,
	input logic result_sign
);

	int unsigned failures = 0;

	busy_done_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(busy && done))
	else
	begin
		failures = failures + 1;
		$error("busy and done are set together");
	end

	pslverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> (psel && penable))
	else
	begin
		failures = failures + 1;
		$error("pslverr raised outside an APB access phase");
	end

	// ReLU output can never be negative.
	result_not_negative: assert property (@(posedge clk) disable iff (!rst_n)
		!result_sign)
	else
	begin
		failures = failures + 1;
		$error("result sign bit is set");
	end

	// Busy covers LANE_ITEMS accumulation cycles plus the last and result pulses.
	busy_length: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(busy) |-> busy [* (LANE_ITEMS + 2)] ##1 !busy)
	else
	begin
		failures = failures + 1;
		$error("busy did not fall after the expected number of cycles");
	end

endmodule

bind node_top node_checker checker_i (
	.clk(pclk),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pslverr(pslverr),
	.busy(regs_i.busy),
	.done(regs_i.done),
	.result_sign(result.raw[31])
);

`default_nettype wire

/* testbench/node_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module node_tb import node_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int N_ROUNDS = 50;
	localparam int XFER_CYCLES = 3;
	localparam int COMPUTE_XFERS = 20;
	localparam int PASS_XFERS = 40;
	localparam int MAX_POLLS = 20;
	localparam logic [31:0] SEED = 32'h0bda_e4d3;
	localparam longint WATCHDOG_NS = longint'(N_ROUNDS + 4)
		* (COMPUTE_XFERS + PASS_XFERS) * XFER_CYCLES * CLK_PERIOD;

	logic pclk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	logic [31:0] rng_state;
	int act_val [N_INPUTS];
	int wgt_val [N_INPUTS];
	logic [31:0] last_result;
	int n_positive;
	int n_clamped;

	node_top dut_i (
		.pclk(pclk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial
	begin
		pclk = 1'b0;
		forever #(CLK_PERIOD / 2) pclk = ~pclk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all tests had finished.");
		$display("Verification failed");
		$fatal(1);
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		rng_state = xorshift(rng_state);
		return lo + int'(rng_state % 32'(hi - lo + 1));
	endfunction

	// Exact single-precision bit pattern of a small integer.
	function automatic logic [31:0] to_float(input int v);
		logic [31:0] mag;
		logic [31:0] shifted;
		int msb;
		if (v == 0)
			return '0;
		mag = (v < 0) ? 32'(-v) : 32'(v);
		msb = 0;
		for (int i = 0; i < 32; i++)
		begin
			if (mag[i])
				msb = i;
		end
		shifted = mag << (23 - msb);
		return {v < 0, 8'(127 + msb), shifted[22:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERR %s expected %h got %h", name, expected, actual);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic apb_access(input logic write, input logic [11:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge pclk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge pclk);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		rdata = prdata;
		err = pslverr;
		check_value("pready", 32'h1, 32'(pready));
		@(negedge pclk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_reg(input logic [11:0] addr, input logic [31:0] data,
		input logic exp_err);
		logic [31:0] rdata;
		logic err;
		apb_access(1'b1, addr, data, rdata, err);
		check_value($sformatf("pslverr@%h", addr), 32'(exp_err), 32'(err));
	endtask

	task automatic read_reg(input logic [11:0] addr, input logic exp_err,
		output logic [31:0] data);
		logic err;
		apb_access(1'b0, addr, '0, data, err);
		check_value($sformatf("pslverr@%h", addr), 32'(exp_err), 32'(err));
	endtask

	task automatic expect_reg(input string name, input logic [11:0] addr,
		input logic [31:0] expected);
		logic [31:0] data;
		read_reg(addr, 1'b0, data);
		check_value(name, expected, data);
	endtask

	task automatic load_random_operands();
		for (int i = 0; i < N_INPUTS; i++)
		begin
			act_val[i] = rand_range(-8, 8);
			wgt_val[i] = rand_range(-4, 4);
			write_reg(ADDR_ACT_BASE + 12'(4 * i), to_float(act_val[i]), 1'b0);
			write_reg(ADDR_WGT_BASE + 12'(4 * i), to_float(wgt_val[i]), 1'b0);
		end
	endtask

	function automatic logic [31:0] relu_model();
		int sum;
		sum = 0;
		for (int i = 0; i < N_INPUTS; i++)
			sum += act_val[i] * wgt_val[i];
		return to_float((sum > 0) ? sum : 0);
	endfunction

	task automatic wait_done();
		logic [31:0] status;
		int polls;
		polls = 0;
		do
		begin
			read_reg(ADDR_STATUS, 1'b0, status);
			polls++;
		end
		while (!status[1] && polls < MAX_POLLS);
		if (!status[1])
		begin
			$display("The node never reported done after a start.");
			$display("Verification failed");
			$fatal(1);
		end
		check_value("STATUS", 32'h2, status);
	endtask

	task automatic run_and_check();
		logic [31:0] expected;
		expected = relu_model();
		write_reg(ADDR_CTRL, 32'h1, 1'b0);
		wait_done();
		expect_reg("RESULT", ADDR_RESULT, expected);
		last_result = expected;
		if (expected == '0)
			n_clamped++;
		else
			n_positive++;
	endtask

	initial
	begin
		logic [31:0] pattern_act [N_INPUTS];
		logic [31:0] pattern_wgt [N_INPUTS];
		logic [31:0] data;
		logic [31:0] expected;

		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rng_state = SEED;
		n_positive = 0;
		n_clamped = 0;
		repeat (2) @(posedge pclk);
		@(negedge pclk);
		rst_n = 1'b1;

		expect_reg("STATUS", ADDR_STATUS, '0);
		expect_reg("RESULT", ADDR_RESULT, '0);
		for (int i = 0; i < N_INPUTS; i += 7)
		begin
			expect_reg($sformatf("ACT[%0d]", i), ADDR_ACT_BASE + 12'(4 * i), '0);
			expect_reg($sformatf("WGT[%0d]", i), ADDR_WGT_BASE + 12'(4 * i), '0);
		end

		for (int i = 0; i < N_INPUTS; i++)
		begin
			rng_state = xorshift(rng_state);
			pattern_act[i] = rng_state;
			rng_state = xorshift(rng_state);
			pattern_wgt[i] = rng_state;
			write_reg(ADDR_ACT_BASE + 12'(4 * i), pattern_act[i], 1'b0);
			write_reg(ADDR_WGT_BASE + 12'(4 * i), pattern_wgt[i], 1'b0);
		end
		for (int i = 0; i < N_INPUTS; i++)
		begin
			expect_reg($sformatf("ACT[%0d]", i), ADDR_ACT_BASE + 12'(4 * i), pattern_act[i]);
			expect_reg($sformatf("WGT[%0d]", i), ADDR_WGT_BASE + 12'(4 * i), pattern_wgt[i]);
		end

		for (int r = 0; r < N_ROUNDS; r++)
		begin
			load_random_operands();
			run_and_check();
		end

		// Three refused accesses fit inside the busy window of one computation.
		load_random_operands();
		expected = relu_model();
		write_reg(ADDR_CTRL, 32'h1, 1'b0);
		write_reg(ADDR_CTRL, 32'h1, 1'b1);
		write_reg(ADDR_ACT_BASE, 32'h4120_0000, 1'b1);
		write_reg(12'h0fc, 32'h1234_5678, 1'b1);
		wait_done();
		expect_reg("RESULT", ADDR_RESULT, expected);
		expect_reg("ACT[0]", ADDR_ACT_BASE, to_float(act_val[0]));
		last_result = expected;

		write_reg(ADDR_STATUS, 32'h3, 1'b1);
		write_reg(ADDR_RESULT, 32'hdead_beef, 1'b1);
		read_reg(12'h03c, 1'b1, data);
		read_reg(12'h07c, 1'b1, data);
		write_reg(12'h08c, 32'h1, 1'b1);
		read_reg(12'h002, 1'b1, data);
		read_reg(12'h800, 1'b1, data);
		expect_reg("RESULT", ADDR_RESULT, last_result);
		expect_reg("STATUS", ADDR_STATUS, 32'h2);
		load_random_operands();
		run_and_check();

		if (dut_i.checker_i.failures != 0)
		begin
			$display("Assertions in the bound checker failed during the run.");
			$display("Verification failed");
			$fatal(1);
		end
		else if (n_positive == 0 || n_clamped == 0)
		begin
			$display("The random rounds did not give both positive and clamped results.");
			$display("Verification failed");
			$fatal(1);
		end
		else
		begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb.f */
design/node_pkg.sv
design/float_mult.sv
design/float_adder.sv
design/node_lane.sv
design/node_combine.sv
design/node_apb_regs.sv
design/node_top.sv
testbench/node_checker.sv
testbench/node_tb.sv

/* Bender.yml */
package:
  name: neuron_node

sources:
  - design/node_pkg.sv
  - design/float_mult.sv
  - design/float_adder.sv
  - design/node_lane.sv
  - design/node_combine.sv
  - design/node_apb_regs.sv
  - design/node_top.sv
  - target: test
    files:
      - testbench/node_checker.sv
      - testbench/node_tb.sv
